/* hdl/scan_cfg.svh */
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// Number of interleaved streams tracked
`define SCAN_STREAMS 64

// Stream id width, log2 of the stream count
`define SCAN_SID_W 6

// One character per strobe
`define SCAN_CHAR_W 8

// Characters of history kept per stream
// One less than the pattern length
`define SCAN_HIST_CHARS 3

// Pattern 0 is "GET " with the first character in the top byte
`define SCAN_PATTERN_0 32'h4745_5420

// Pattern 1 is "EVIL"
`define SCAN_PATTERN_1 32'h4556_494C

// Per-matcher packet count width
`define SCAN_COUNT_W 16

`endif

/* hdl/scan_pkg.sv */
`include "scan_cfg.svh"

package scan_pkg;

   // One character of the input stream
   typedef logic [`SCAN_CHAR_W-1:0] char_t;

   // Stream id as given by the host
   typedef logic [`SCAN_SID_W-1:0] sid_t;

   // Last characters seen on a stream, newest in the low byte
   // All zero means empty history
   typedef logic [`SCAN_HIST_CHARS*`SCAN_CHAR_W-1:0] hist_t;

   // Count of packets that fired
   typedef logic [`SCAN_COUNT_W-1:0] count_t;

   // Context address, stream id on top and matcher index below
   typedef logic [`SCAN_SID_W:0] ctx_addr_t;

   // Full pattern width, history plus the newest character
   localparam int PATTERN_W = (`SCAN_HIST_CHARS + 1) * `SCAN_CHAR_W;

   // Each matcher owns one half of the context memory
   localparam int CTX_DEPTH = 2 * `SCAN_STREAMS;

   // Context slot for one stream of one matcher
   function automatic ctx_addr_t make_ctx_addr(sid_t sid, bit idx);
      return {sid, idx};
   endfunction

endpackage

/* hdl/ctx_mem_if.sv */
`timescale 1ns/1ps

interface ctx_mem_if;

   // Request side, held steady by the matcher until gnt
   logic req;
   logic we;
   scan_pkg::ctx_addr_t addr;
   scan_pkg::hist_t wdata;

   // Grant is a single cycle, read data follows one cycle later
   logic gnt;
   scan_pkg::hist_t rdata;

   modport matcher (
      output req,
      output we,
      output addr,
      output wdata,
      input  gnt,
      input  rdata
   );

   modport arbiter (
      input  req,
      input  we,
      input  addr,
      input  wdata,
      output gnt,
      output rdata
   );

endinterface

/* hdl/pattern_dfa.sv */
`timescale 1ns/1ps

module pattern_dfa (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [scan_pkg::PATTERN_W-1:0]     pattern,
   input  scan_pkg::hist_t                    hist_in,
   input  logic                               hist_load,
   input  scan_pkg::char_t                    char_in,
   input  logic                               char_in_vld,
   output scan_pkg::hist_t                    hist_out,
   output logic                               accept
);

   localparam int CHAR_W = $bits(scan_pkg::char_t);
   localparam int HIST_W = $bits(scan_pkg::hist_t);

   // Last characters of the current stream, newest in the low byte
   scan_pkg::hist_t hist;

   // History plus the incoming character, compared against the pattern
   logic [scan_pkg::PATTERN_W-1:0] window;

   assign window = {hist, char_in};

   // Match is flagged in the same cycle as the completing character
   // Caller registers it
   assign accept = char_in_vld && !hist_load && (window == pattern);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         hist <= '0;
      end
      else if (hist_load)
      begin
         // Restore or clear wins over any character
         hist <= hist_in;
      end
      else if (char_in_vld)
      begin
         // Drop the oldest character, shift the new one in
         hist <= {hist[HIST_W-CHAR_W-1:0], char_in};
      end
   end

   // Saved as the stream context at end of packet
   assign hist_out = hist;

endmodule

/* hdl/stream_matcher.sv */
`timescale 1ns/1ps

module stream_matcher #(
   parameter logic [scan_pkg::PATTERN_W-1:0] PATTERN = '0,
   parameter bit                             INDEX   = 1'b0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              load_state,
   input  logic              new_stream_id,
   input  scan_pkg::sid_t    stream_id,
   input  scan_pkg::char_t   char_in,
   input  logic              char_in_vld,
   input  logic              eop,
   input  logic              enable,
   ctx_mem_if.matcher        mem,
   output scan_pkg::count_t  count,
   output logic              fired,
   output logic              busy
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_HOLD,
      S_RD_REQ,
      S_RD_DATA,
      S_WR_REQ
   } state_t;

   state_t state;

   // Context slot of the stream opened by the last load_state
   scan_pkg::ctx_addr_t addr_q;

   // Recognizer side
   scan_pkg::hist_t hist_in;
   scan_pkg::hist_t hist_out;
   logic            hist_load;
   logic            dfa_vld;
   logic            accept;

   logic idle;

   assign idle = (state == S_IDLE);
   assign busy = !idle;

   // Characters during a restore or save are a host error, drop them
   assign dfa_vld = char_in_vld && idle;

   // New stream clears history at once, a restore loads the read data
   assign hist_load = (state == S_RD_DATA) || (idle && load_state && new_stream_id);
   assign hist_in   = (state == S_RD_DATA) ? mem.rdata : '0;

   // Memory request follows the state, dropped the cycle after gnt
   assign mem.req   = (state == S_RD_REQ) || (state == S_WR_REQ);
   assign mem.we    = (state == S_WR_REQ);
   assign mem.addr  = addr_q;
   assign mem.wdata = hist_out;

   pattern_dfa pattern_dfa_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .pattern     (PATTERN),
      .hist_in     (hist_in),
      .hist_load   (hist_load),
      .char_in     (char_in),
      .char_in_vld (dfa_vld),
      .hist_out    (hist_out),
      .accept      (accept)
   );

   // Stream slot is latched at load and reused for the save at eop
   always_ff @(posedge clk)
   begin
      if (idle && load_state)
      begin
         addr_q <= scan_pkg::make_ctx_addr(stream_id, INDEX);
      end
   end

   // Restore and save sequencing
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= S_IDLE;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (load_state)
               begin
                  // New stream needs no fetch, just one busy cycle
                  state <= new_stream_id ? S_HOLD : S_RD_REQ;
               end
               else if (eop)
               begin
                  // Disabled matcher saves nothing
                  state <= enable ? S_WR_REQ : S_HOLD;
               end
            end
            S_HOLD:
            begin
               state <= S_IDLE;
            end
            S_RD_REQ:
            begin
               if (mem.gnt)
                  state <= S_RD_DATA;
            end
            S_RD_DATA:
            begin
               // History is loaded this cycle
               state <= S_IDLE;
            end
            S_WR_REQ:
            begin
               // Write happens in the gnt cycle
               if (mem.gnt)
                  state <= S_IDLE;
            end
            default:
            begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // Fired flag and packet count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         fired <= 1'b0;
      end
      else
      begin
         // Start of packet clears the flag
         if (idle && load_state)
            fired <= 1'b0;

         // Any match in this packet sets it
         if (accept)
            fired <= 1'b1;

         if (idle && eop)
         begin
            if (enable)
               count <= count + scan_pkg::count_t'(fired);
            else
               fired <= 1'b0;
         end
      end
   end

endmodule

/* hdl/ctx_arbiter.sv */
`timescale 1ns/1ps

module ctx_arbiter (
   input  logic        clk,
   input  logic        rst_n,
   ctx_mem_if.arbiter  m0,
   ctx_mem_if.arbiter  m1
);

   // Saved history per stream and matcher, contents not reset
   scan_pkg::hist_t ctx_mem [scan_pkg::CTX_DEPTH];

   // Round-robin pointer, low favors matcher 0
   logic prio;

   // Selected request
   logic                pick1;
   logic                any_req;
   logic                sel_we;
   scan_pkg::ctx_addr_t sel_addr;
   scan_pkg::hist_t     sel_wdata;

   // Registered read data, shared by both matchers
   scan_pkg::hist_t rdata_q;

   assign any_req = m0.req || m1.req;

   // Matcher 1 wins when alone or when it holds priority
   assign pick1 = m1.req && (!m0.req || prio);

   // One grant per cycle at most
   assign m0.gnt = m0.req && !pick1;
   assign m1.gnt = pick1;

   assign sel_we    = pick1 ? m1.we    : m0.we;
   assign sel_addr  = pick1 ? m1.addr  : m0.addr;
   assign sel_wdata = pick1 ? m1.wdata : m0.wdata;

   // Only the granted matcher looks at rdata, one cycle after gnt
   assign m0.rdata = rdata_q;
   assign m1.rdata = rdata_q;

   // Pointer moves only when both ask
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         prio <= 1'b0;
      end
      else if (m0.req && m1.req)
      begin
         prio <= !prio;
      end
   end

   // Single-port access in the gnt cycle
   always_ff @(posedge clk)
   begin
      if (any_req)
      begin
         if (sel_we)
            ctx_mem[sel_addr] <= sel_wdata;
         rdata_q <= ctx_mem[sel_addr];
      end
   end

endmodule

/* hdl/stream_scanner.sv */
`timescale 1ns/1ps

`include "scan_cfg.svh"

module stream_scanner (
   input  logic              clk,
   input  logic              rst_n,
   input  scan_pkg::char_t   char_in,
   input  logic              char_in_vld,
   input  scan_pkg::sid_t    stream_id,
   input  logic              new_stream_id,
   input  logic              load_state,
   input  logic              eop,
   input  logic [1:0]        enable,
   output scan_pkg::count_t  count_0,
   output scan_pkg::count_t  count_1,
   output logic [1:0]        fired,
   output logic              ready
);

   // Per-matcher restore or save in progress
   logic busy_0;
   logic busy_1;

   // One context memory port per matcher
   ctx_mem_if mem_0 ();
   ctx_mem_if mem_1 ();

   // Matcher 0 looks for "GET "
   stream_matcher #(
      .PATTERN (`SCAN_PATTERN_0),
      .INDEX   (1'b0)
   ) stream_matcher_0_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .enable        (enable[0]),
      .mem           (mem_0.matcher),
      .count         (count_0),
      .fired         (fired[0]),
      .busy          (busy_0)
   );

   // Matcher 1 looks for "EVIL"
   stream_matcher #(
      .PATTERN (`SCAN_PATTERN_1),
      .INDEX   (1'b1)
   ) stream_matcher_1_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .enable        (enable[1]),
      .mem           (mem_1.matcher),
      .count         (count_1),
      .fired         (fired[1]),
      .busy          (busy_1)
   );

   // Shared context memory, round-robin between the matchers
   ctx_arbiter ctx_arbiter_i (
      .clk   (clk),
      .rst_n (rst_n),
      .m0    (mem_0.arbiter),
      .m1    (mem_1.arbiter)
   );

   // Host may continue once both matchers are idle
   assign ready = !(busy_0 || busy_1);

endmodule

/* bench/stream_scanner_tb.sv */
`timescale 1ns/1ps

module stream_scanner_tb;

   localparam int NUM_ROWS = 18;

   // Each packet needs well under 30 cycles even with contention
   localparam int MAX_CYCLES = NUM_ROWS * 30;

   // One packet of the table with its expected results
   typedef struct packed {
      scan_pkg::sid_t          sid;
      logic                    new_stream;
      scan_pkg::char_t [7:0]   chars;
      logic [3:0]              len;
      logic [1:0]              en;
      logic [1:0]              exp_fired;
      scan_pkg::count_t        exp_count_0;
      scan_pkg::count_t        exp_count_1;
   } row_t;

   logic              clk;
   logic              rst_n;
   scan_pkg::char_t   char_in;
   logic              char_in_vld;
   scan_pkg::sid_t    stream_id;
   logic              new_stream_id;
   logic              load_state;
   logic              eop;
   logic [1:0]        enable;
   scan_pkg::count_t  count_0;
   scan_pkg::count_t  count_1;
   logic [1:0]        fired;
   logic              ready;

   row_t rows [NUM_ROWS];
   int   n_rows;
   int   cycles;

   stream_scanner stream_scanner_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .load_state    (load_state),
      .eop           (eop),
      .enable        (enable),
      .count_0       (count_0),
      .count_1       (count_1),
      .fired         (fired),
      .ready         (ready)
   );

   // 8 ns clock
   always #4 clk = !clk;

   task automatic abort_run(input string reason);
      $display("Test failed");
      $fatal(1, "%s", reason);
   endtask

   // Watchdog on the whole run
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
         abort_run("Run timed out waiting for ready or for the table to finish");
   end

   task automatic check_fired(input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp)
      begin
         $display("CHECK FAILED time %0t fired expected %b actual %b", $time, exp, act);
         abort_run("fired flags differ from the expected pair");
      end
   endtask

   task automatic check_count(input string name, input scan_pkg::count_t exp,
                              input scan_pkg::count_t act);
      if (act !== exp)
      begin
         $display("CHECK FAILED time %0t %s expected %0d actual %0d", $time, name, exp, act);
         abort_run("packet count differs from the expected value");
      end
   endtask

   task automatic check_ready(input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("CHECK FAILED time %0t ready expected %b actual %b", $time, exp, act);
         abort_run("ready level differs from the expected value");
      end
   endtask

   // Appends one packet, characters sent in string order
   task automatic add_row(input int sid, input logic new_stream, input string text,
                          input logic [1:0] en, input logic [1:0] exp_fired,
                          input int exp_c0, input int exp_c1);
      row_t row;
      row = '0;
      row.sid = scan_pkg::sid_t'(sid);
      row.new_stream = new_stream;
      for (int i = 0; i < text.len(); i++)
         row.chars[i] = text.getc(i);
      row.len = 4'(text.len());
      row.en = en;
      row.exp_fired = exp_fired;
      row.exp_count_0 = scan_pkg::count_t'(exp_c0);
      row.exp_count_1 = scan_pkg::count_t'(exp_c1);
      rows[n_rows] = row;
      n_rows++;
   endtask

   // Matcher 0 is "GET ", matcher 1 is "EVIL", enable and fired bit 0 is matcher 0
   task automatic build_table();
      n_rows = 0;
      // Whole pattern inside one packet
      add_row(5,  1'b1, "aGET b", 2'b11, 2'b01, 1, 0);
      add_row(5,  1'b0, "xEVILq", 2'b11, 2'b10, 1, 1);
      // Split across packets of one stream
      add_row(5,  1'b0, "zzEV",   2'b11, 2'b00, 1, 1);
      add_row(5,  1'b0, "ILGE",   2'b11, 2'b10, 1, 2);
      add_row(5,  1'b0, "T xy",   2'b11, 2'b01, 2, 2);
      // New stream drops the "EV" prefix
      add_row(5,  1'b0, "abcEV",  2'b11, 2'b00, 2, 2);
      add_row(5,  1'b1, "IL",     2'b11, 2'b00, 2, 2);
      // Matcher 0 disabled, its saved "cGE" survives
      add_row(5,  1'b0, "abcGE",  2'b11, 2'b00, 2, 2);
      add_row(5,  1'b0, "T EVIL", 2'b10, 2'b11, 2, 3);
      add_row(5,  1'b0, "T x",    2'b11, 2'b01, 3, 3);
      // Interleaved streams with different partial prefixes
      add_row(42, 1'b1, "GE",     2'b11, 2'b00, 3, 3);
      add_row(17, 1'b1, "EV",     2'b11, 2'b00, 3, 3);
      add_row(42, 1'b0, "T ",     2'b11, 2'b01, 4, 3);
      add_row(17, 1'b0, "IL",     2'b11, 2'b10, 4, 4);
      add_row(5,  1'b0, "GEVI",   2'b11, 2'b00, 4, 4);
      add_row(42, 1'b0, "EVIL",   2'b11, 2'b10, 4, 5);
      add_row(5,  1'b0, "L",      2'b11, 2'b10, 4, 6);
      add_row(17, 1'b0, "GET ",   2'b11, 2'b01, 5, 6);
   endtask

   // Polls at negedge, ready has been low since the edge after the strobe
   task automatic wait_ready();
      while (ready !== 1'b1)
         @(negedge clk);
   endtask

   // Load, characters, eop, then the count check once ready returns
   task automatic send_packet(input row_t row);
      stream_id = row.sid;
      new_stream_id = row.new_stream;
      load_state = 1'b1;
      @(negedge clk);
      load_state = 1'b0;
      new_stream_id = 1'b0;
      // Restore or clear in progress since the edge that took the strobe
      check_ready(1'b0, ready);
      wait_ready();
      for (int i = 0; i < int'(row.len); i++)
      begin
         char_in = row.chars[i];
         char_in_vld = 1'b1;
         @(negedge clk);
         char_in_vld = 1'b0;
         // One idle gap inside the packet
         if (i == 1)
            @(negedge clk);
      end
      // Fired holds the result of the last character here
      check_fired(row.exp_fired, fired);
      enable = row.en;
      eop = 1'b1;
      @(negedge clk);
      eop = 1'b0;
      // Save or hold cycle started at the eop edge
      check_ready(1'b0, ready);
      wait_ready();
      check_count("count_0", row.exp_count_0, count_0);
      check_count("count_1", row.exp_count_1, count_1);
      // A disabled matcher drops its flag at eop
      check_fired(row.exp_fired & row.en, fired);
   endtask

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      char_in = '0;
      char_in_vld = 1'b0;
      stream_id = '0;
      new_stream_id = 1'b0;
      load_state = 1'b0;
      eop = 1'b0;
      enable = 2'b00;
      build_table();

      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // Idle state after reset
      check_fired(2'b00, fired);
      check_count("count_0", '0, count_0);
      check_count("count_1", '0, count_1);
      check_ready(1'b1, ready);

      for (int r = 0; r < n_rows; r++)
         send_packet(rows[r]);

      $display("Test completed successfully");
      $finish;
   end

endmodule

/* stream_scanner.f */
+incdir+hdl
hdl/scan_pkg.sv
hdl/ctx_mem_if.sv
hdl/pattern_dfa.sv
hdl/stream_matcher.sv
hdl/ctx_arbiter.sv
hdl/stream_scanner.sv
bench/stream_scanner_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
# Exit status is nonzero when the build fails or the run ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module stream_scanner_tb \
   -f stream_scanner.f \
   -o stream_scanner_sim \
   && ./obj_dir/stream_scanner_sim \
   || exit 1
